// ==== src/mmu_cfg_pkg.sv ====
package mmu_cfg_pkg;

    // ----------------------------------------
    // SV39 address format
    // ----------------------------------------

    // register and cause width
    localparam int unsigned XLEN = 64;
    // virtual address as seen by the load/store unit
    localparam int unsigned VLEN = 64;
    // physical address width, upper bits of paddr_t are zero
    localparam int unsigned PLEN = 56;
    localparam int unsigned PPN_W = 44;
    // three levels of 9 bits each
    localparam int unsigned VPN_W = 27;
    localparam int unsigned PG_OFS_W = 12;
    localparam int unsigned LVL_W = 9;
    localparam int unsigned ASID_W = 16;

    // ----------------------------------------
    // data TLB sizing
    // ----------------------------------------

    localparam int unsigned DTLB_ENTRIES = 4;
    localparam int unsigned DTLB_IDX_W = $clog2(DTLB_ENTRIES);

    // ----------------------------------------
    // vector types
    // ----------------------------------------

    typedef logic [VLEN-1:0] vaddr_t;
    typedef logic [XLEN-1:0] paddr_t;
    typedef logic [PPN_W-1:0] ppn_t;
    typedef logic [VPN_W-1:0] vpn_t;
    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [XLEN-1:0] cause_t;
    // slot index inside the data TLB
    typedef logic [DTLB_IDX_W-1:0] tlb_idx_t;

endpackage

// ==== src/mmu_rec_pkg.sv ====
package mmu_rec_pkg;

    // ----------------------------------------
    // privilege and exception codes
    // ----------------------------------------

    // effective privilege of the load/store access
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    // mcause values of the two data page faults
    localparam mmu_cfg_pkg::cause_t LOAD_PAGE_FAULT = 64'd13;
    localparam mmu_cfg_pkg::cause_t STORE_PAGE_FAULT = 64'd15;

    // ----------------------------------------
    // records
    // ----------------------------------------

    // leaf PTE, only the fields kept in the TLB
    typedef struct packed {
        mmu_cfg_pkg::ppn_t ppn;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_t;

    // one refill written from outside
    typedef struct packed {
        logic valid;
        logic is_2m;
        logic is_1g;
        mmu_cfg_pkg::vpn_t vpn;
        mmu_cfg_pkg::asid_t asid;
        pte_t content;
    } tlb_update_t;

    // exception record as returned to the LSU
    typedef struct packed {
        mmu_cfg_pkg::cause_t cause;
        mmu_cfg_pkg::vaddr_t tval;
        logic valid;
    } exception_t;

    // combinational TLB answer
    typedef struct packed {
        logic hit;
        logic is_2m;
        logic is_1g;
        pte_t content;
    } lookup_t;

    // stage 1 view, from the request register to the fault checks
    typedef struct packed {
        logic req;
        logic is_store;
        // translation on and no misaligned exception
        logic translate;
        logic hit;
        pte_t content;
        mmu_cfg_pkg::vaddr_t vaddr;
        mmu_cfg_pkg::paddr_t paddr;
        exception_t misaligned_ex;
    } xlat_t;

endpackage

// ==== src/dtlb.sv ====
`timescale 1ns/1ps

module dtlb (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  mmu_rec_pkg::tlb_update_t update_i,
    input  logic                     lu_access_i,
    input  mmu_cfg_pkg::asid_t       lu_asid_i,
    input  mmu_cfg_pkg::vaddr_t      lu_vaddr_i,
    output mmu_rec_pkg::lookup_t     lu_o,
    output logic                     miss_o
);
    import mmu_cfg_pkg::*;
    import mmu_rec_pkg::*;

    // per entry state, valid bits carry the reset
    logic [DTLB_ENTRIES-1:0] valid_q;
    logic [DTLB_ENTRIES-1:0] is_2m_q;
    logic [DTLB_ENTRIES-1:0] is_1g_q;
    vpn_t vpn_q [DTLB_ENTRIES];
    asid_t asid_q [DTLB_ENTRIES];
    pte_t pte_q [DTLB_ENTRIES];

    // round robin victim once every slot is in use
    tlb_idx_t victim_q;
    tlb_idx_t repl_idx;
    logic have_free;

    vpn_t lu_vpn;
    logic [DTLB_ENTRIES-1:0] asid_ok;
    logic [DTLB_ENTRIES-1:0] match;

    assign lu_vpn = lu_vaddr_i[PG_OFS_W +: VPN_W];

    // ----------------------------------------
    // lookup
    // ----------------------------------------
    always_comb begin : tag_match
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            // global pages ignore the address space
            asid_ok[i] = (asid_q[i] == lu_asid_i) || pte_q[i].g;
            // level 2 always, level 1 unless giga, level 0 only for 4k
            match[i] = valid_q[i] && asid_ok[i]
                && (vpn_q[i][2*LVL_W +: LVL_W] == lu_vpn[2*LVL_W +: LVL_W])
                && (is_1g_q[i] || (vpn_q[i][LVL_W +: LVL_W] == lu_vpn[LVL_W +: LVL_W]))
                && (is_1g_q[i] || is_2m_q[i] || (vpn_q[i][0 +: LVL_W] == lu_vpn[0 +: LVL_W]));
        end
    end

    always_comb begin : hit_select
        lu_o = '0;
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            if (match[i]) begin
                lu_o.hit = 1'b1;
                lu_o.is_2m = is_2m_q[i];
                lu_o.is_1g = is_1g_q[i];
                lu_o.content = pte_q[i];
            end
        end
    end

    // counted as a miss only when someone asked
    assign miss_o = lu_access_i & ~lu_o.hit;

    // ----------------------------------------
    // refill and flush
    // ----------------------------------------
    always_comb begin : refill_slot
        repl_idx = victim_q;
        have_free = 1'b0;
        // walk down so the lowest free slot wins
        for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                repl_idx = tlb_idx_t'(i);
                have_free = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
        if (!rst_ni) begin
            valid_q <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            // flush beats a refill in the same cycle
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[repl_idx] <= 1'b1;
            if (!have_free) begin
                victim_q <= (victim_q == tlb_idx_t'(DTLB_ENTRIES - 1)) ?
                    '0 : victim_q + tlb_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin : entry_regs
        if (update_i.valid && !flush_i) begin
            is_2m_q[repl_idx] <= update_i.is_2m;
            is_1g_q[repl_idx] <= update_i.is_1g;
            vpn_q[repl_idx] <= update_i.vpn;
            asid_q[repl_idx] <= update_i.asid;
            pte_q[repl_idx] <= update_i.content;
        end
    end

endmodule

// ==== src/ldst_translate.sv ====
`timescale 1ns/1ps

module ldst_translate (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    lsu_req_i,
    input  mmu_cfg_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                    lsu_is_store_i,
    input  mmu_rec_pkg::exception_t misaligned_ex_i,
    input  logic                    en_ld_st_translation_i,
    input  mmu_rec_pkg::lookup_t    lu_i,
    output logic                    lsu_dtlb_hit_o,
    output mmu_rec_pkg::xlat_t      xlat_o
);
    import mmu_cfg_pkg::*;
    import mmu_rec_pkg::*;

    // control part of the stage register
    logic req_q;
    logic translate_q;
    logic hit_q;
    logic mis_valid_q;

    // payload part
    vaddr_t vaddr_q;
    logic is_store_q;
    logic is_2m_q;
    logic is_1g_q;
    pte_t pte_q;
    cause_t mis_cause_q;
    vaddr_t mis_tval_q;

    // misaligned record only counts together with a request
    logic mis_valid_d;
    paddr_t paddr;

    assign mis_valid_d = misaligned_ex_i.valid & lsu_req_i;

    // untranslated requests are always ready in cycle 0
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lu_i.hit : 1'b1;

    // ----------------------------------------
    // stage register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            req_q <= 1'b0;
            translate_q <= 1'b0;
            hit_q <= 1'b0;
            mis_valid_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            translate_q <= en_ld_st_translation_i & ~mis_valid_d;
            hit_q <= lu_i.hit;
            mis_valid_q <= mis_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        vaddr_q <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        is_2m_q <= lu_i.is_2m;
        is_1g_q <= lu_i.is_1g;
        pte_q <= lu_i.content;
        mis_cause_q <= misaligned_ex_i.cause;
        mis_tval_q <= misaligned_ex_i.tval;
    end

    // ----------------------------------------
    // address composition
    // ----------------------------------------
    always_comb begin : compose
        paddr = vaddr_q;
        if (translate_q) begin
            paddr = '0;
            // 4k page, ppn joined with offset
            paddr[PLEN-1:0] = {pte_q.ppn, vaddr_q[PG_OFS_W-1:0]};
            // mega page keeps vpn[0] from the virtual address
            if (is_2m_q) begin
                paddr[PG_OFS_W +: LVL_W] = vaddr_q[PG_OFS_W +: LVL_W];
            end
            // giga page keeps vpn[1] and vpn[0]
            if (is_1g_q) begin
                paddr[PG_OFS_W +: 2*LVL_W] = vaddr_q[PG_OFS_W +: 2*LVL_W];
            end
        end
    end

    always_comb begin : pack_stage
        xlat_o.req = req_q;
        xlat_o.is_store = is_store_q;
        xlat_o.translate = translate_q;
        xlat_o.hit = hit_q;
        xlat_o.content = pte_q;
        xlat_o.vaddr = vaddr_q;
        xlat_o.paddr = paddr;
        xlat_o.misaligned_ex = '{cause: mis_cause_q, tval: mis_tval_q, valid: mis_valid_q};
    end

endmodule

// ==== src/ldst_fault.sv ====
`timescale 1ns/1ps

module ldst_fault (
    input  mmu_rec_pkg::xlat_t      xlat_i,
    input  mmu_rec_pkg::priv_lvl_e  ld_st_priv_lvl_i,
    input  logic                    sum_i,
    output logic                    lsu_valid_o,
    output mmu_cfg_pkg::paddr_t     lsu_paddr_o,
    output mmu_rec_pkg::exception_t lsu_exception_o
);
    import mmu_rec_pkg::*;

    // privilege violation on the cached pte
    logic access_err;
    // store specific violation, write or dirty missing
    logic store_err;
    logic lu_hit;

    // ----------------------------------------
    // permission checks
    // ----------------------------------------

    // user page from S mode needs SUM, U mode may only touch user pages
    assign access_err =
        ((ld_st_priv_lvl_i == PRIV_LVL_S) && !sum_i && xlat_i.content.u) ||
        ((ld_st_priv_lvl_i == PRIV_LVL_U) && !xlat_i.content.u);

    // dirty bit is not set by hardware, so a clean page faults
    assign store_err = !xlat_i.content.w || !xlat_i.content.d || access_err;

    assign lu_hit = xlat_i.req & xlat_i.hit;

    // address is already composed in the stage before
    assign lsu_paddr_o = xlat_i.paddr;

    // ----------------------------------------
    // result selection
    // ----------------------------------------
    always_comb begin : result
        // bare mode or misaligned, plain pass through
        lsu_valid_o = xlat_i.req;
        lsu_exception_o = xlat_i.misaligned_ex;

        if (xlat_i.translate) begin
            // a miss stays silent, requester refills and retries
            lsu_valid_o = lu_hit;
            if (lu_hit) begin
                if (xlat_i.is_store) begin
                    if (store_err) begin
                        lsu_exception_o = '{
                            cause: STORE_PAGE_FAULT,
                            tval: xlat_i.vaddr,
                            valid: 1'b1
                        };
                    end
                end else if (access_err) begin
                    lsu_exception_o = '{
                        cause: LOAD_PAGE_FAULT,
                        tval: xlat_i.vaddr,
                        valid: 1'b1
                    };
                end
            end
        end
    end

endmodule

// ==== src/mmu_ldst.sv ====
`timescale 1ns/1ps

module mmu_ldst (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // load/store request, cycle 0
    input  logic                     lsu_req_i,
    input  mmu_cfg_pkg::vaddr_t      lsu_vaddr_i,
    input  logic                     lsu_is_store_i,
    input  mmu_rec_pkg::exception_t  misaligned_ex_i,
    // translation control
    input  logic                     en_ld_st_translation_i,
    input  mmu_rec_pkg::priv_lvl_e   ld_st_priv_lvl_i,
    input  logic                     sum_i,
    input  mmu_cfg_pkg::asid_t       asid_i,
    input  logic                     flush_tlb_i,
    input  mmu_rec_pkg::tlb_update_t tlb_update_i,
    // cycle 0 strobes
    output logic                     lsu_dtlb_hit_o,
    output logic                     dtlb_miss_o,
    // cycle 1 result
    output logic                     lsu_valid_o,
    output mmu_cfg_pkg::paddr_t      lsu_paddr_o,
    output mmu_rec_pkg::exception_t  lsu_exception_o
);
    import mmu_rec_pkg::*;

    // TLB answer into the stage register
    lookup_t dtlb_lu;
    // registered request towards the checks
    xlat_t xlat;

    // ----------------------------------------
    // lookup
    // ----------------------------------------
    dtlb dtlb_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_tlb_i),
        .update_i    (tlb_update_i),
        .lu_access_i (lsu_req_i),
        .lu_asid_i   (asid_i),
        .lu_vaddr_i  (lsu_vaddr_i),
        .lu_o        (dtlb_lu),
        .miss_o      (dtlb_miss_o)
    );

    // ----------------------------------------
    // translate
    // ----------------------------------------
    ldst_translate ldst_translate_inst (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .lsu_req_i              (lsu_req_i),
        .lsu_vaddr_i            (lsu_vaddr_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .misaligned_ex_i        (misaligned_ex_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lu_i                   (dtlb_lu),
        .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
        .xlat_o                 (xlat)
    );

    // ----------------------------------------
    // fault
    // ----------------------------------------
    ldst_fault ldst_fault_inst (
        .xlat_i           (xlat),
        .ld_st_priv_lvl_i (ld_st_priv_lvl_i),
        .sum_i            (sum_i),
        .lsu_valid_o      (lsu_valid_o),
        .lsu_paddr_o      (lsu_paddr_o),
        .lsu_exception_o  (lsu_exception_o)
    );

endmodule

// ==== testbench/mmu_ldst_assertions.sv ====
`timescale 1ns/1ps

module mmu_ldst_assertions (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    lsu_req_i,
    input logic                    en_ld_st_translation_i,
    input logic                    lsu_dtlb_hit_o,
    input logic                    dtlb_miss_o,
    input logic                    lsu_valid_o,
    input mmu_rec_pkg::exception_t lsu_exception_o
);

    // ----------------------------------------
    // protocol properties
    // ----------------------------------------

    // idle cycle gives an idle result one cycle later
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !lsu_req_i |=> !lsu_valid_o)
        else $error("lsu_valid_o high without a request in the cycle before");

    // hit and miss exclude each other under translation
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        en_ld_st_translation_i |-> !(dtlb_miss_o && lsu_dtlb_hit_o))
        else $error("dtlb_miss_o and lsu_dtlb_hit_o high together");

    // an exception always rides on a valid result
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exception_o.valid |-> lsu_valid_o)
        else $error("exception reported without lsu_valid_o");

endmodule

bind mmu_ldst mmu_ldst_assertions mmu_ldst_assertions_inst (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .lsu_req_i              (lsu_req_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_exception_o        (lsu_exception_o)
);

// ==== testbench/tb_mmu_ldst.sv ====
`timescale 1ns/1ps

module tb_mmu_ldst;
    import mmu_cfg_pkg::*;
    import mmu_rec_pkg::*;

    localparam int unsigned HALF_PERIOD = 10;
    localparam int unsigned NUM_TESTS = 6;
    // per test budget plus the reset cycles
    localparam int unsigned WATCHDOG_CYCLES = 10 + 200 * NUM_TESTS;

    logic clk_i = 1'b0;
    logic rst_ni, lsu_req_i, lsu_is_store_i, en_ld_st_translation_i, sum_i, flush_tlb_i;
    vaddr_t lsu_vaddr_i;
    exception_t misaligned_ex_i;
    priv_lvl_e ld_st_priv_lvl_i;
    asid_t asid_i;
    tlb_update_t tlb_update_i;
    logic lsu_dtlb_hit_o, dtlb_miss_o, lsu_valid_o;
    paddr_t lsu_paddr_o;
    exception_t lsu_exception_o;

    // mode applied together with the next request
    logic cur_en, cur_sum;
    priv_lvl_e cur_priv;
    asid_t cur_asid;
    // cycle 0 strobes and cycle 1 result of the last request
    logic hit0, miss0, valid1;
    paddr_t pa1;
    exception_t exc1;

    mmu_ldst mmu_ldst_inst (.*);

    always #HALF_PERIOD clk_i = ~clk_i;

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input string name, input exception_t got, input exception_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // drivers
    // ----------------------------------------
    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    // one request with the strobes sampled mid cycle 0 and the result mid cycle 1
    task automatic issue_req(input vaddr_t va, input logic store, input exception_t mis);
        step();
        en_ld_st_translation_i = cur_en;
        ld_st_priv_lvl_i = cur_priv;
        sum_i = cur_sum;
        asid_i = cur_asid;
        lsu_req_i = 1'b1;
        lsu_vaddr_i = va;
        lsu_is_store_i = store;
        misaligned_ex_i = mis;
        #8;
        hit0 = lsu_dtlb_hit_o;
        miss0 = dtlb_miss_o;
        step();
        lsu_req_i = 1'b0;
        misaligned_ex_i = '0;
        #8;
        valid1 = lsu_valid_o;
        pa1 = lsu_paddr_o;
        exc1 = lsu_exception_o;
    endtask

    task automatic refill(input vaddr_t va, input ppn_t ppn, input logic u, input logic w,
                          input logic d, input logic is_2m, input logic is_1g);
        step();
        tlb_update_i = '{valid: 1'b1, is_2m: is_2m, is_1g: is_1g, vpn: va[38:12],
            asid: cur_asid, content: '{ppn: ppn, d: d, a: 1'b1, g: 1'b0, u: u,
            x: 1'b0, w: w, r: 1'b1, v: 1'b1}};
        step();
        tlb_update_i = '0;
    endtask

    task automatic flush_all();
        step();
        flush_tlb_i = 1'b1;
        step();
        flush_tlb_i = 1'b0;
    endtask

    task automatic expect_ok(input vaddr_t va, input logic store, input paddr_t exp_pa);
        issue_req(va, store, '0);
        check_bit("lsu_dtlb_hit_o", hit0, 1'b1);
        if (cur_en) begin
            check_bit("dtlb_miss_o", miss0, 1'b0);
        end
        check_bit("lsu_valid_o", valid1, 1'b1);
        check_paddr("lsu_paddr_o", pa1, exp_pa);
        check_bit("lsu_exception_o.valid", exc1.valid, 1'b0);
    endtask

    task automatic expect_fault(input vaddr_t va, input logic store, input cause_t cause);
        issue_req(va, store, '0);
        check_bit("lsu_valid_o", valid1, 1'b1);
        check_exc("lsu_exception_o", exc1, '{cause: cause, tval: va, valid: 1'b1});
    endtask

    // a miss pulses in cycle 0 and leaves no valid strobe
    task automatic expect_miss(input vaddr_t va);
        issue_req(va, 1'b0, '0);
        check_bit("dtlb_miss_o", miss0, 1'b1);
        check_bit("lsu_dtlb_hit_o", hit0, 1'b0);
        check_bit("lsu_valid_o", valid1, 1'b0);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_bare();
        vaddr_t va;
        cur_en = 1'b0;
        repeat (4) begin
            va = {$urandom, $urandom};
            expect_ok(va, 1'($urandom), va);
        end
    endtask

    task automatic test_4k();
        vaddr_t va;
        ppn_t ppn;
        cur_en = 1'b1;
        va = {$urandom, $urandom};
        ppn = ppn_t'({$urandom, $urandom});
        flush_all();
        refill(va, ppn, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        expect_ok(va, 1'b0, {8'h00, ppn, va[11:0]});
        // store to another offset in the same page
        va[11:0] = 12'($urandom);
        expect_ok(va, 1'b1, {8'h00, ppn, va[11:0]});
    endtask

    task automatic test_superpages();
        vaddr_t base2m, base1g, va;
        ppn_t ppn2m, ppn1g;
        base2m = {$urandom, $urandom};
        // level 2 differs so both entries never match one address
        base1g = base2m ^ (64'h1 << 38);
        ppn2m = ppn_t'({$urandom, $urandom});
        ppn1g = ppn_t'({$urandom, $urandom});
        flush_all();
        refill(base2m, ppn2m, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
        refill(base1g, ppn1g, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        repeat (3) begin
            va = {base2m[63:21], 21'($urandom)};
            expect_ok(va, 1'b0, {8'h00, ppn2m[43:9], va[20:0]});
            va = {base1g[63:30], 30'($urandom)};
            expect_ok(va, 1'b0, {8'h00, ppn1g[43:18], va[29:0]});
        end
    endtask

    task automatic test_perm();
        vaddr_t va_u, va_s, va_ro, va_cl;
        va_u = {$urandom, $urandom};
        va_s = va_u ^ 64'h1000;
        va_ro = va_u ^ 64'h2000;
        va_cl = va_u ^ 64'h3000;
        flush_all();
        // user page, supervisor page, read only page, clean page
        refill(va_u, ppn_t'(1), 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        refill(va_s, ppn_t'(2), 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        refill(va_ro, ppn_t'(3), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        refill(va_cl, ppn_t'(4), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        expect_fault(va_u, 1'b0, LOAD_PAGE_FAULT);
        cur_sum = 1'b1;
        expect_ok(va_u, 1'b0, {8'h00, ppn_t'(1), va_u[11:0]});
        cur_sum = 1'b0;
        cur_priv = PRIV_LVL_U;
        expect_fault(va_s, 1'b0, LOAD_PAGE_FAULT);
        expect_ok(va_u, 1'b1, {8'h00, ppn_t'(1), va_u[11:0]});
        cur_priv = PRIV_LVL_S;
        expect_fault(va_ro, 1'b1, STORE_PAGE_FAULT);
        expect_fault(va_cl, 1'b1, STORE_PAGE_FAULT);
        expect_ok(va_s, 1'b1, {8'h00, ppn_t'(2), va_s[11:0]});
    endtask

    task automatic test_miss();
        vaddr_t va;
        ppn_t ppn;
        va = {$urandom, $urandom};
        ppn = ppn_t'({$urandom, $urandom});
        flush_all();
        refill(va, ppn, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        cur_asid = 16'h0022;
        expect_miss(va);
        cur_asid = 16'h0011;
        expect_ok(va, 1'b0, {8'h00, ppn, va[11:0]});
        flush_all();
        expect_miss(va);
    endtask

    task automatic test_misaligned();
        vaddr_t va;
        exception_t mis;
        va = {$urandom, $urandom};
        // load address misaligned with the faulting address as tval
        mis = '{cause: 64'd4, tval: va, valid: 1'b1};
        flush_all();
        issue_req(va, 1'b0, mis);
        check_bit("dtlb_miss_o", miss0, 1'b1);
        check_bit("lsu_valid_o", valid1, 1'b1);
        check_exc("lsu_exception_o", exc1, mis);
    endtask

    initial begin : main
        void'($urandom(32'habfd));
        rst_ni = 1'b0;
        lsu_req_i = 1'b0;
        lsu_vaddr_i = '0;
        lsu_is_store_i = 1'b0;
        misaligned_ex_i = '0;
        en_ld_st_translation_i = 1'b0;
        ld_st_priv_lvl_i = PRIV_LVL_S;
        sum_i = 1'b0;
        asid_i = '0;
        flush_tlb_i = 1'b0;
        tlb_update_i = '0;
        cur_en = 1'b1;
        cur_sum = 1'b0;
        cur_priv = PRIV_LVL_S;
        cur_asid = 16'h0011;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        test_bare();
        test_4k();
        test_superpages();
        test_perm();
        test_miss();
        test_misaligned();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
src/mmu_cfg_pkg.sv
src/mmu_rec_pkg.sv
src/dtlb.sv
src/ldst_translate.sv
src/ldst_fault.sv
src/mmu_ldst.sv
testbench/mmu_ldst_assertions.sv
testbench/tb_mmu_ldst.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mmu_ldst testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_mmu_ldst -o Vtb_mmu_ldst

./obj_dir/Vtb_mmu_ldst | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
